// File: hw/prf_defines.svh
`ifndef PRF_DEFINES_SVH
`define PRF_DEFINES_SVH

// number of physical registers, any power of two from 4 up
`define PRF_SIZE 32

// width of one physical register
`define PRF_DATA_WIDTH 64

// index into the register file, 5 bits at the default size
`define PRF_IDX_WIDTH $clog2(`PRF_SIZE)

`endif

// File: hw/prf_pkg.sv
`default_nettype none
`include "prf_defines.svh"

package prf_pkg;

	// life cycle of one physical register
	typedef enum logic [1:0] {
		ENTRY_FREE  = 2'd0, // on the free list, can be granted to a rename port
		ENTRY_WAIT  = 2'd1, // granted, its producer has not broadcast yet
		ENTRY_READY = 2'd2  // value captured from a cdb, readable by issue
	} prf_entry_state_t;

	typedef logic [`PRF_IDX_WIDTH-1:0] prf_idx_t;

	//////////////////////////////////////////////////////////////
	// port bundles
	//////////////////////////////////////////////////////////////

	typedef struct packed {
		logic valid;
		prf_idx_t tag; // physical register the result belongs to
		logic [`PRF_DATA_WIDTH-1:0] value;
	} cdb_bcast_t;

	typedef struct packed {
		logic valid; // low when no entry was free or nothing was asked for
		prf_idx_t idx;
	} rename_grant_t;

	typedef struct packed {
		logic valid;
		prf_idx_t idx; // old mapping released when an instruction retires
	} retire_free_t;

	typedef struct packed {
		logic valid; // the operand is there, the instruction can take it
		logic [`PRF_DATA_WIDTH-1:0] value;
	} operand_read_t;

endpackage

`default_nettype wire

// File: hw/prf_one_entry.sv
`default_nettype none
`timescale 1ns/1ps
`include "prf_defines.svh"

module prf_one_entry
	import prf_pkg::*;
(
	input wire logic clock,
	input wire logic reset,
	input wire logic free_this_entry, // retire or recovery free, beats everything else
	input wire logic write_enable, // cdb hit while this entry waits
	input wire logic [`PRF_DATA_WIDTH-1:0] data_in,
	input wire logic allocate, // this entry was granted to a rename port
	output prf_entry_state_t state,
	output logic [`PRF_DATA_WIDTH-1:0] data_out
);

	prf_entry_state_t next_state;

	// free wins over a grant or a write landing in the same cycle
	always_comb
	begin
		next_state = state;
		if (free_this_entry)
			next_state = ENTRY_FREE;
		else
		begin
			case (state)
				ENTRY_FREE:
					if (allocate)
						next_state = ENTRY_WAIT; // rename took it, value still in flight
				ENTRY_WAIT:
					if (write_enable)
						next_state = ENTRY_READY; // producer broadcast on a cdb
				ENTRY_READY:
					next_state = ENTRY_READY; // stays readable until released
				default:
					next_state = ENTRY_FREE; // the spare encoding falls back to free
			endcase
		end
	end

	always_ff @(posedge clock)
	begin
		if (reset)
			state <= ENTRY_FREE; // every register starts on the free list
		else
			state <= next_state;
	end

	// the value itself only moves when a cdb writes it
	always_ff @(posedge clock)
	begin
		if (write_enable)
			data_out <= data_in;
	end

endmodule

`default_nettype wire

// File: hw/priority_selector.sv
`default_nettype none
`timescale 1ns/1ps

module priority_selector #(
	parameter int SIZE = 32 // number of request lines
) (
	input wire logic [SIZE-1:0] req, // one bit per candidate, bit 0 is the favourite
	input wire logic en, // nothing is granted while this is low
	output logic [SIZE-1:0] gnt // one hot, or all zero
);

	// scan from the top down so the lowest set request is the last to write gnt
	always_comb
	begin
		gnt = '0;
		if (en)
		begin
			for (int i = SIZE - 1; i >= 0; i--)
			begin
				if (req[i])
				begin
					gnt = '0; // drop whatever a higher request picked
					gnt[i] = 1'b1;
				end
			end
		end
	end

	// with no request set the loop never fires and gnt stays zero,
	// so callers read an empty grant as nothing available

endmodule

`default_nettype wire

// File: hw/prf.sv
`default_nettype none
`timescale 1ns/1ps
`include "prf_defines.svh"

module prf
	import prf_pkg::*;
(
	input wire logic clock,
	input wire logic reset,

	// result broadcasts
	input wire cdb_bcast_t cdb1,
	input wire cdb_bcast_t cdb2,

	// operand reads for the two issuing instructions
	input wire prf_idx_t inst1_opa_idx,
	input wire prf_idx_t inst1_opb_idx,
	input wire prf_idx_t inst2_opa_idx,
	input wire prf_idx_t inst2_opb_idx,
	output operand_read_t inst1_opa_read,
	output operand_read_t inst1_opb_read,
	output operand_read_t inst2_opa_read,
	output operand_read_t inst2_opb_read,

	// rename requests and their grants
	input wire logic rat1_allocate,
	input wire logic rat2_allocate,
	output rename_grant_t rat1_grant,
	output rename_grant_t rat2_grant,

	// retirement frees
	input wire retire_free_t rrat1_free,
	input wire retire_free_t rrat2_free,

	// mispredict recovery
	input wire logic rrat1_recover,
	input wire logic rrat2_recover,
	input wire logic [`PRF_SIZE-1:0] rrat1_free_list,
	input wire logic [`PRF_SIZE-1:0] rrat2_free_list,
	input wire logic [`PRF_SIZE-1:0] rat1_free_list,
	input wire logic [`PRF_SIZE-1:0] rat2_free_list
);

	prf_entry_state_t entry_state [`PRF_SIZE]; // per entry life cycle
	logic [`PRF_SIZE-1:0][`PRF_DATA_WIDTH-1:0] entry_data; // stored values
	logic [`PRF_SIZE-1:0] entry_free; // entry can be handed out
	logic [`PRF_SIZE-1:0] entry_wait; // entry accepts a cdb write
	logic [`PRF_SIZE-1:0] entry_ready; // entry can be read
	logic [`PRF_SIZE-1:0] gnt1; // one hot grant to rat1
	logic [`PRF_SIZE-1:0] gnt2; // one hot grant to rat2
	logic [`PRF_SIZE-1:0] write_enable;
	logic [`PRF_SIZE-1:0][`PRF_DATA_WIDTH-1:0] write_data;
	logic [`PRF_SIZE-1:0] free_entry;

	//////////////////////////////////////////////////////////////
	// entry array
	//////////////////////////////////////////////////////////////

	for (genvar i = 0; i < `PRF_SIZE; i++)
	begin : g_entry
		prf_one_entry u_entry (
			.clock(clock),
			.reset(reset),
			.free_this_entry(free_entry[i]),
			.write_enable(write_enable[i]),
			.data_in(write_data[i]),
			.allocate(gnt1[i] | gnt2[i]), // the two grants never overlap
			.state(entry_state[i]),
			.data_out(entry_data[i])
		);

		// each flag looks at this one entry only
		assign entry_free[i] = (entry_state[i] == ENTRY_FREE);
		assign entry_wait[i] = (entry_state[i] == ENTRY_WAIT);
		assign entry_ready[i] = (entry_state[i] == ENTRY_READY);
	end

	//////////////////////////////////////////////////////////////
	// rename grants
	//////////////////////////////////////////////////////////////

	priority_selector #(.SIZE(`PRF_SIZE)) u_sel1 (
		.req(entry_free),
		.en(rat1_allocate),
		.gnt(gnt1)
	);

	// rat2 sees the free list minus whatever rat1 just took
	priority_selector #(.SIZE(`PRF_SIZE)) u_sel2 (
		.req(entry_free & ~gnt1),
		.en(rat2_allocate),
		.gnt(gnt2)
	);

	// turn the one hot grants back into an index
	always_comb
	begin
		rat1_grant = '0;
		rat2_grant = '0;
		for (int i = 0; i < `PRF_SIZE; i++)
		begin
			if (gnt1[i])
			begin
				rat1_grant.valid = 1'b1;
				rat1_grant.idx = prf_idx_t'(i);
			end
			if (gnt2[i])
			begin
				rat2_grant.valid = 1'b1;
				rat2_grant.idx = prf_idx_t'(i);
			end
		end
	end

	//////////////////////////////////////////////////////////////
	// cdb capture
	//////////////////////////////////////////////////////////////

	// only a waiting entry takes a broadcast, cdb1 first on a shared tag
	always_comb
	begin
		for (int i = 0; i < `PRF_SIZE; i++)
		begin
			write_enable[i] = 1'b0;
			write_data[i] = '0;
			if (entry_wait[i] && cdb1.valid && (cdb1.tag == prf_idx_t'(i)))
			begin
				write_enable[i] = 1'b1;
				write_data[i] = cdb1.value;
			end
			else if (entry_wait[i] && cdb2.valid && (cdb2.tag == prf_idx_t'(i)))
			begin
				write_enable[i] = 1'b1;
				write_data[i] = cdb2.value;
			end
		end
	end

	//////////////////////////////////////////////////////////////
	// operand reads
	//////////////////////////////////////////////////////////////

	// a register that is not ready reads as all zero with valid low
	function automatic operand_read_t read_operand(
		input prf_idx_t idx,
		input logic [`PRF_SIZE-1:0] ready,
		input logic [`PRF_SIZE-1:0][`PRF_DATA_WIDTH-1:0] data
	);
		operand_read_t rd;
		rd = '0;
		if (ready[idx])
		begin
			rd.valid = 1'b1;
			rd.value = data[idx];
		end
		return rd;
	endfunction

	always_comb
	begin
		inst1_opa_read = read_operand(inst1_opa_idx, entry_ready, entry_data);
		inst1_opb_read = read_operand(inst1_opb_idx, entry_ready, entry_data);
		inst2_opa_read = read_operand(inst2_opa_idx, entry_ready, entry_data);
		inst2_opb_read = read_operand(inst2_opb_idx, entry_ready, entry_data);
	end

	//////////////////////////////////////////////////////////////
	// free decode
	//////////////////////////////////////////////////////////////

	always_comb
	begin
		free_entry = '0;
		// on a mispredict drop whatever neither the committed nor the other
		// speculative table still points at, pairing rrat1 with rat2 and vice versa
		if (rrat1_recover)
			free_entry = rrat1_free_list & rat2_free_list;
		else if (rrat2_recover)
			free_entry = rrat2_free_list & rat1_free_list;
		else
		begin
			for (int i = 0; i < `PRF_SIZE; i++)
			begin
				if (rrat1_free.valid && (rrat1_free.idx == prf_idx_t'(i)))
					free_entry[i] = 1'b1; // retired from slot 1
				if (rrat2_free.valid && (rrat2_free.idx == prf_idx_t'(i)))
					free_entry[i] = 1'b1; // retired from slot 2
			end
		end
	end

endmodule

`default_nettype wire

// File: test/prf_checker.sv
`default_nettype none
`timescale 1ns/1ps

module prf_checker
	import prf_pkg::*;
(
	input wire logic clock,
	input wire logic check_en,
	input wire logic [127:0] test_name, // name packed as characters
	input wire rename_grant_t exp_g1,
	input wire rename_grant_t exp_g2,
	input wire operand_read_t exp_ra, // value expected at index a on inst1 opa and inst2 opb
	input wire operand_read_t exp_rb, // value expected at index b on inst1 opb and inst2 opa
	input wire rename_grant_t g1,
	input wire rename_grant_t g2,
	input wire operand_read_t ra1,
	input wire operand_read_t rb1,
	input wire operand_read_t ra2,
	input wire operand_read_t rb2,
	output int error_count
);

	logic [127:0] cur_name;
	int test_errs;
	int errs;
	int passed;
	int failed;

	initial
	begin
		cur_name = '0;
		test_errs = 0;
		errs = 0;
		passed = 0;
		failed = 0;
	end

	assign error_count = errs;

	task automatic compare_field(input string field, input logic [71:0] exp, input logic [71:0] act);
		if (exp !== act)
		begin
			$display("[FAIL] %0s %0s expected %h actual %h", cur_name, field, exp, act);
			test_errs++;
			errs++;
		end
	endtask

	// closes the running test with one line
	task automatic close_test();
		if (cur_name != '0)
		begin
			if (test_errs == 0)
			begin
				$display("PASS %0s", cur_name);
				passed++;
			end
			else
			begin
				$display("test %0s had %0d mismatches", cur_name, test_errs);
				failed++;
			end
		end
	endtask

	task automatic report();
		close_test();
		cur_name = '0;
		$display("tests passed %0d, tests failed %0d, mismatches %0d", passed, failed, errs);
	endtask

	// inputs move 1 ns after the rising edge so the falling edge sees settled outputs
	always @(negedge clock)
	begin
		if (check_en)
		begin
			if (test_name != cur_name)
			begin
				close_test();
				cur_name = test_name;
				test_errs = 0;
			end
			compare_field("rat1_grant", 72'(exp_g1), 72'(g1));
			compare_field("rat2_grant", 72'(exp_g2), 72'(g2));
			compare_field("inst1_opa_read", 72'(exp_ra), 72'(ra1));
			compare_field("inst1_opb_read", 72'(exp_rb), 72'(rb1));
			compare_field("inst2_opa_read", 72'(exp_rb), 72'(ra2));
			compare_field("inst2_opb_read", 72'(exp_ra), 72'(rb2));
		end
	end

endmodule

`default_nettype wire

// File: test/prf_chk.sv
`default_nettype none
`timescale 1ns/1ps
`include "prf_defines.svh"

module prf_chk
	import prf_pkg::*;
(
	input wire logic clock,
	input wire logic reset,
	input wire logic rat1_allocate,
	input wire logic rat2_allocate,
	input wire rename_grant_t rat1_grant,
	input wire rename_grant_t rat2_grant,
	input wire prf_idx_t inst1_opa_idx,
	input wire operand_read_t inst1_opa_read,
	input wire prf_idx_t inst2_opb_idx,
	input wire operand_read_t inst2_opb_read,
	input wire prf_entry_state_t entry_state [`PRF_SIZE]
);

	// two rename ports must never share a register
	assert property (@(posedge clock) disable iff (reset)
		(rat1_grant.valid && rat2_grant.valid) |-> (rat1_grant.idx != rat2_grant.idx))
		else $error("both rename ports got the same register");

	assert property (@(posedge clock) disable iff (reset)
		(!rat1_grant.valid || rat1_allocate) && (!rat2_grant.valid || rat2_allocate))
		else $error("grant without a request");

	// a valid read only comes from a ready entry
	assert property (@(posedge clock) disable iff (reset)
		(!inst1_opa_read.valid || entry_state[inst1_opa_idx] == ENTRY_READY)
		&& (!inst2_opb_read.valid || entry_state[inst2_opb_idx] == ENTRY_READY))
		else $error("read valid on an entry that is not ready");

endmodule

bind prf prf_chk u_chk (
	.clock(clock), .reset(reset),
	.rat1_allocate(rat1_allocate), .rat2_allocate(rat2_allocate),
	.rat1_grant(rat1_grant), .rat2_grant(rat2_grant),
	.inst1_opa_idx(inst1_opa_idx), .inst1_opa_read(inst1_opa_read),
	.inst2_opb_idx(inst2_opb_idx), .inst2_opb_read(inst2_opb_read),
	.entry_state(entry_state)
);

`default_nettype wire

// File: test/prf_tb.sv
`default_nettype none
`timescale 1ns/1ps
`include "prf_defines.svh"

module prf_tb
	import prf_pkg::*;
();

	logic clock;
	logic reset;
	cdb_bcast_t cdb1, cdb2;
	prf_idx_t ia, ib; // the second instruction reads the same two indices crossed over
	operand_read_t ra1, rb1, ra2, rb2;
	logic rat1_allocate, rat2_allocate;
	rename_grant_t rat1_grant, rat2_grant;
	retire_free_t rrat1_free, rrat2_free;
	logic rrat1_recover, rrat2_recover;
	logic [`PRF_SIZE-1:0] rrat1_list, rrat2_list, rat1_list, rat2_list;

	logic check_en; // high while a stimulus line is applied
	logic [127:0] test_name;
	rename_grant_t exp_g1, exp_g2;
	operand_read_t exp_ra, exp_rb;
	int error_count;
	int bad_lines;
	int cycles;
	int limit;
	int fd;
	string line;
	string lines[$];

	prf DUT (
		.clock(clock), .reset(reset), .cdb1(cdb1), .cdb2(cdb2),
		.inst1_opa_idx(ia), .inst1_opb_idx(ib), .inst2_opa_idx(ib), .inst2_opb_idx(ia),
		.inst1_opa_read(ra1), .inst1_opb_read(rb1),
		.inst2_opa_read(ra2), .inst2_opb_read(rb2),
		.rat1_allocate(rat1_allocate), .rat2_allocate(rat2_allocate),
		.rat1_grant(rat1_grant), .rat2_grant(rat2_grant),
		.rrat1_free(rrat1_free), .rrat2_free(rrat2_free),
		.rrat1_recover(rrat1_recover), .rrat2_recover(rrat2_recover),
		.rrat1_free_list(rrat1_list), .rrat2_free_list(rrat2_list),
		.rat1_free_list(rat1_list), .rat2_free_list(rat2_list)
	);

	prf_checker u_checker (
		.clock(clock), .check_en(check_en), .test_name(test_name),
		.exp_g1(exp_g1), .exp_g2(exp_g2), .exp_ra(exp_ra), .exp_rb(exp_rb),
		.g1(rat1_grant), .g2(rat2_grant), .ra1(ra1), .rb1(rb1), .ra2(ra2), .rb2(rb2),
		.error_count(error_count)
	);

	initial
	begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	// puts every input in its idle state before reset and after the last line
	task automatic drive_idle();
		cdb1 = '0;
		cdb2 = '0;
		ia = '0;
		ib = '0;
		rat1_allocate = 1'b0;
		rat2_allocate = 1'b0;
		rrat1_free = '0;
		rrat2_free = '0;
		rrat1_recover = 1'b0;
		rrat2_recover = 1'b0;
		rrat1_list = '0;
		rrat2_list = '0;
		rat1_list = '0;
		rat2_list = '0;
	endtask

	// one line holds a name, 20 input columns and 8 expected columns
	task automatic apply_line(input string text);
		int n;
		int r1, r2, c1v, c1t, c2v, c2t, xa, xb, f1v, f1i, f2v, f2i, rc1, rc2;
		int g1v, g1i, g2v, g2i, rav, rbv;
		logic [63:0] c1val, c2val, raval, rbval;
		logic [31:0] l0, l1, l2, l3;
		logic [127:0] nm;
		n = $sscanf(text, "%s %d %d %d %d %h %d %d %h %d %d %d %d %d %d %d %d %h %h %h %h %d %d %d %d %d %h %d %h",
			nm, r1, r2, c1v, c1t, c1val, c2v, c2t, c2val, xa, xb, f1v, f1i, f2v, f2i,
			rc1, rc2, l0, l1, l2, l3, g1v, g1i, g2v, g2i, rav, raval, rbv, rbval);
		if (n != 29)
		begin
			$display("stimulus line could not be parsed: %s", text);
			bad_lines++;
			check_en = 1'b0;
		end
		else
		begin
			test_name = nm;
			rat1_allocate = r1[0];
			rat2_allocate = r2[0];
			cdb1 = '{valid: c1v[0], tag: prf_idx_t'(c1t), value: c1val};
			cdb2 = '{valid: c2v[0], tag: prf_idx_t'(c2t), value: c2val};
			ia = prf_idx_t'(xa);
			ib = prf_idx_t'(xb);
			rrat1_free = '{valid: f1v[0], idx: prf_idx_t'(f1i)};
			rrat2_free = '{valid: f2v[0], idx: prf_idx_t'(f2i)};
			rrat1_recover = rc1[0];
			rrat2_recover = rc2[0];
			rrat1_list = l0;
			rrat2_list = l1;
			rat1_list = l2;
			rat2_list = l3;
			exp_g1 = '{valid: g1v[0], idx: prf_idx_t'(g1i)};
			exp_g2 = '{valid: g2v[0], idx: prf_idx_t'(g2i)};
			exp_ra = '{valid: rav[0], value: raval};
			exp_rb = '{valid: rbv[0], value: rbval};
			check_en = 1'b1;
		end
	endtask

	// the limit follows the number of lines once the file is read
	always @(posedge clock)
	begin
		cycles++;
		if (cycles > limit)
		begin
			$display("timeout, the run went past %0d cycles", limit);
			$display("Simulation failed");
			$finish;
		end
	end

	initial
	begin
		cycles = 0;
		limit = 1000;
		bad_lines = 0;
		check_en = 1'b0;
		test_name = '0;
		exp_g1 = '0;
		exp_g2 = '0;
		exp_ra = '0;
		exp_rb = '0;
		reset = 1'b1;
		drive_idle();
		fd = $fopen("test/prf_stimulus.txt", "r");
		if (fd == 0)
		begin
			$display("cannot open test/prf_stimulus.txt");
			bad_lines++;
		end
		else
		begin
			while ($fgets(line, fd))
				if (line.len() > 1 && line.getc(0) != "#") // skip comments and blank lines
					lines.push_back(line);
			$fclose(fd);
		end
		limit = lines.size() + 16 + 20;
		repeat (16) @(posedge clock);
		#1 reset = 1'b0;
		foreach (lines[i])
		begin
			@(posedge clock);
			#1 apply_line(lines[i]);
		end
		@(posedge clock);
		#1 check_en = 1'b0;
		drive_idle();
		u_checker.report();
		if (error_count == 0 && bad_lines == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: test/prf_stimulus.txt
# name r1 r2 | c1v c1tag c1val c2v c2tag c2val | ia ib | f1v f1i f2v f2i | rec1 rec2 rrat1 rrat2 rat1 rat2 lists
# then expected: g1v g1i g2v g2i | a_valid a_value b_valid b_value   (idx decimal, values and lists hex)
alloc 1 1 0 0 0 0 0 0 0 1 0 0 0 0 0 0 0 0 0 0 1 0 1 1 0 0 0 0
alloc 1 1 0 0 0 0 0 0 0 1 0 0 0 0 0 0 0 0 0 0 1 2 1 3 0 0 0 0
alloc 1 1 0 0 0 0 0 0 0 1 0 0 0 0 0 0 0 0 0 0 1 4 1 5 0 0 0 0
alloc 1 1 0 0 0 0 0 0 0 1 0 0 0 0 0 0 0 0 0 0 1 6 1 7 0 0 0 0
alloc 1 1 0 0 0 0 0 0 0 1 0 0 0 0 0 0 0 0 0 0 1 8 1 9 0 0 0 0
alloc 1 1 0 0 0 0 0 0 0 1 0 0 0 0 0 0 0 0 0 0 1 10 1 11 0 0 0 0
alloc 1 1 0 0 0 0 0 0 0 1 0 0 0 0 0 0 0 0 0 0 1 12 1 13 0 0 0 0
alloc 1 1 0 0 0 0 0 0 0 1 0 0 0 0 0 0 0 0 0 0 1 14 1 15 0 0 0 0
alloc 1 1 0 0 0 0 0 0 0 1 0 0 0 0 0 0 0 0 0 0 1 16 1 17 0 0 0 0
alloc 1 1 0 0 0 0 0 0 0 1 0 0 0 0 0 0 0 0 0 0 1 18 1 19 0 0 0 0
alloc 1 1 0 0 0 0 0 0 0 1 0 0 0 0 0 0 0 0 0 0 1 20 1 21 0 0 0 0
alloc 1 1 0 0 0 0 0 0 0 1 0 0 0 0 0 0 0 0 0 0 1 22 1 23 0 0 0 0
alloc 1 1 0 0 0 0 0 0 0 1 0 0 0 0 0 0 0 0 0 0 1 24 1 25 0 0 0 0
alloc 1 1 0 0 0 0 0 0 0 1 0 0 0 0 0 0 0 0 0 0 1 26 1 27 0 0 0 0
alloc 1 1 0 0 0 0 0 0 0 1 0 0 0 0 0 0 0 0 0 0 1 28 1 29 0 0 0 0
alloc 1 1 0 0 0 0 0 0 0 1 0 0 0 0 0 0 0 0 0 0 1 30 1 31 0 0 0 0
alloc 1 1 0 0 0 0 0 0 0 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
cdb 0 0 1 3 1111 0 0 0 3 4 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
cdb 0 0 0 0 0 0 0 0 3 4 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 1111 0 0
cdb_dual 0 0 1 5 aa 1 6 bb 5 6 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
cdb_dual 0 0 0 0 0 0 0 0 5 6 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 aa 1 bb
cdb_same 0 0 1 7 11 1 7 22 7 6 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 bb
cdb_same 0 0 0 0 0 0 0 0 7 6 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 11 1 bb
retire 0 0 0 0 0 0 0 0 3 4 1 3 0 0 0 0 0 0 0 0 0 0 0 0 1 1111 0 0
retire 1 0 0 0 0 0 0 0 3 4 0 0 0 0 0 0 0 0 0 0 1 3 0 0 0 0 0 0
free_cdb 0 0 0 0 0 0 0 0 9 3 0 0 1 9 0 0 0 0 0 0 0 0 0 0 0 0 0 0
free_cdb 0 0 1 9 99 0 0 0 9 3 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
free_cdb 0 0 0 0 0 0 0 0 9 3 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
recover 0 0 0 0 0 0 0 0 12 16 1 20 0 0 1 1 f000 f0000 f0000 5000 0 0 0 0 0 0 0 0
recover 1 1 0 0 0 0 0 0 12 16 0 0 0 0 0 0 0 0 0 0 1 9 1 12 0 0 0 0
recover 1 1 0 0 0 0 0 0 12 16 0 0 0 0 0 0 0 0 0 0 1 14 0 0 0 0 0 0

// File: sources.f
+incdir+hw
hw/prf_pkg.sv
hw/prf_one_entry.sv
hw/priority_selector.sv
hw/prf.sv
test/prf_checker.sv
test/prf_chk.sv
test/prf_tb.sv

// File: run_sim.sh
#!/bin/sh
# build with Verilator, run, then judge the log
verilator --binary --timing --assert -Wno-fatal -f sources.f --top-module prf_tb \
	-o prf_sim > build.log 2>&1 && ./obj_dir/prf_sim > sim.log 2>&1 \
	|| { echo "build or run error, see build.log and sim.log"; exit 1; }
grep -q "Simulation failed" sim.log && { echo "FAIL"; exit 1; }
grep -q "Simulation completed successfully" sim.log || { echo "FAIL, no result"; exit 1; }
echo "PASS"
exit 0
